// File: design/riscv_csr_pkg.sv
//----------------------------------------------------------------------
// architectural definitions for the machine-mode CSR file of an RV64 core
// holds CSR addresses, privilege levels, cause codes and write masks
// imported by every RTL module of the CSR file
//----------------------------------------------------------------------
package riscv_csr_pkg;

    // data path and address widths
    localparam int XLEN       = 64;
    localparam int CSR_ADDR_W = 12;

    // only machine and user mode are implemented
    typedef enum logic [1:0] {
        PRIV_LVL_U = 2'b00,
        PRIV_LVL_M = 2'b11
    } priv_lvl_t;

    //------------------------------------------------------------------
    // CSR address map
    //------------------------------------------------------------------
    // bits 9:8 of an address give the lowest privilege allowed to access it
    typedef enum logic [CSR_ADDR_W-1:0] {
        CSR_MSTATUS  = 12'h300,
        CSR_MISA     = 12'h301,
        CSR_MIE      = 12'h304,
        CSR_MTVEC    = 12'h305,
        CSR_MSCRATCH = 12'h340,
        CSR_MEPC     = 12'h341,
        CSR_MCAUSE   = 12'h342,
        CSR_MTVAL    = 12'h343,
        // user level counters, read only
        CSR_CYCLE    = 12'hC00,
        CSR_INSTRET  = 12'hC02
    } csr_addr_e;

    //------------------------------------------------------------------
    // write masks and constants
    //------------------------------------------------------------------
    // mie (bit 3), mpie (bit 7), mpp (bits 12:11)
    localparam logic [XLEN-1:0] MSTATUS_MASK = 64'h0000_0000_0000_1888;
    // user software, timer and external interrupt enables stay zero
    localparam logic [XLEN-1:0] MIE_MASK     = 64'hFFFF_FFFF_FFFF_FEEE;
    // MXL = 64 bit, extensions A, I, M and U
    localparam logic [XLEN-1:0] ISA_CODE     = 64'h8000_0000_0010_1101;

    // exception cause codes
    localparam logic [XLEN-1:0] ILLEGAL_INSTR = 64'd2;

    // mstatus layout, fields outside the mask read as zero
    typedef struct packed {
        logic [63:13] wpri3;
        priv_lvl_t    mpp;
        logic [10:8]  wpri2;
        logic         mpie;
        logic [6:4]   wpri1;
        logic         mie;
        logic [2:0]   wpri0;
    } mstatus_t;

endpackage

// File: design/csr_core_pkg.sv
//----------------------------------------------------------------------
// port definitions between the core pipeline and the CSR file
// operation codes plus request, response, exception and trap structs
//----------------------------------------------------------------------
package csr_core_pkg;

    // operation presented by the core together with the CSR address
    typedef enum logic [2:0] {
        CSR_NONE  = 3'd0,
        CSR_READ  = 3'd1,
        CSR_WRITE = 3'd2,
        CSR_SET   = 3'd3,
        CSR_CLEAR = 3'd4,
        MRET      = 3'd5
    } csr_op_e;

    // one request per cycle, always accepted
    typedef struct packed {
        csr_op_e                              op;
        logic [riscv_csr_pkg::CSR_ADDR_W-1:0] addr;
        logic [riscv_csr_pkg::XLEN-1:0]       wdata;
    } csr_req_t;

    // exception as reported by the commit stage or raised by the CSR file
    typedef struct packed {
        logic                           valid;
        logic [riscv_csr_pkg::XLEN-1:0] cause;
        logic [riscv_csr_pkg::XLEN-1:0] tval;
    } exception_t;

    // same cycle answer to a request
    typedef struct packed {
        logic [riscv_csr_pkg::XLEN-1:0] rdata;
        exception_t                     exception;
    } csr_rsp_t;

    //------------------------------------------------------------------
    // toward PC generation
    //------------------------------------------------------------------
    typedef struct packed {
        // return from trap, jump to epc
        logic                           eret;
        logic [riscv_csr_pkg::XLEN-1:0] epc;
        // base of the trap handler
        logic [riscv_csr_pkg::XLEN-1:0] trap_vector_base;
    } trap_ctrl_t;

endpackage

// File: design/csr_op_decode.sv
//----------------------------------------------------------------------
// decodes the CSR operation into read, write and mret intent
// forms the final write data for set and clear from the current value
//----------------------------------------------------------------------
`timescale 1ns/1ps

module csr_op_decode (
    input  csr_core_pkg::csr_op_e            op_i,
    input  logic [riscv_csr_pkg::XLEN-1:0]   wdata_i,
    // current value of the addressed CSR
    input  logic [riscv_csr_pkg::XLEN-1:0]   rdata_i,
    output logic                             read_o,
    output logic                             write_o,
    output logic                             mret_o,
    output logic [riscv_csr_pkg::XLEN-1:0]   wdata_o
);
    import csr_core_pkg::*;

    always_comb begin
        // no access unless the op asks for one
        read_o  = 1'b0;
        write_o = 1'b0;
        mret_o  = 1'b0;
        wdata_o = wdata_i;
        case (op_i)
            CSR_READ: begin
                read_o = 1'b1;
            end
            CSR_WRITE: begin
                read_o  = 1'b1;
                write_o = 1'b1;
            end
            // read-modify-write, bits of wdata_i select what changes
            CSR_SET: begin
                read_o  = 1'b1;
                write_o = 1'b1;
                wdata_o = wdata_i | rdata_i;
            end
            CSR_CLEAR: begin
                read_o  = 1'b1;
                write_o = 1'b1;
                wdata_o = rdata_i & ~wdata_i;
            end
            // return from trap has no CSR side effect
            MRET: begin
                mret_o = 1'b1;
            end
            default: begin
                read_o  = 1'b0;
                write_o = 1'b0;
            end
        endcase
    end

endmodule

// File: design/csr_access.sv
//----------------------------------------------------------------------
// read multiplexer and access checks of the CSR file
// raises an illegal instruction for unknown, read-only or privileged
// addresses and only lets a clean write through to the register state
//----------------------------------------------------------------------
`timescale 1ns/1ps

module csr_access (
    input  logic [riscv_csr_pkg::CSR_ADDR_W-1:0] addr_i,
    input  logic                                 read_i,
    input  logic                                 write_i,
    input  riscv_csr_pkg::priv_lvl_t             priv_lvl_i,
    // register views
    input  riscv_csr_pkg::mstatus_t              mstatus_i,
    input  logic [riscv_csr_pkg::XLEN-1:0]       mie_i,
    input  logic [riscv_csr_pkg::XLEN-1:0]       mtvec_i,
    input  logic [riscv_csr_pkg::XLEN-1:0]       mscratch_i,
    input  logic [riscv_csr_pkg::XLEN-1:0]       mepc_i,
    input  logic [riscv_csr_pkg::XLEN-1:0]       mcause_i,
    input  logic [riscv_csr_pkg::XLEN-1:0]       mtval_i,
    input  logic [riscv_csr_pkg::XLEN-1:0]       cycle_i,
    input  logic [riscv_csr_pkg::XLEN-1:0]       instret_i,
    output logic [riscv_csr_pkg::XLEN-1:0]       rdata_o,
    output csr_core_pkg::exception_t             exception_o,
    output logic                                 write_en_o
);
    import riscv_csr_pkg::*;

    logic known;
    logic read_only;
    logic priv_fail;
    logic illegal;

    //------------------------------------------------------------------
    // read data and address decode
    //------------------------------------------------------------------
    always_comb begin
        rdata_o   = '0;
        known     = 1'b1;
        read_only = 1'b0;
        case (csr_addr_e'(addr_i))
            CSR_MSTATUS:  rdata_o = mstatus_i;
            // misa is a constant, writes are not allowed
            CSR_MISA: begin
                rdata_o   = ISA_CODE;
                read_only = 1'b1;
            end
            CSR_MIE:      rdata_o = mie_i;
            CSR_MTVEC:    rdata_o = mtvec_i;
            CSR_MSCRATCH: rdata_o = mscratch_i;
            CSR_MEPC:     rdata_o = mepc_i;
            CSR_MCAUSE:   rdata_o = mcause_i;
            CSR_MTVAL:    rdata_o = mtval_i;
            CSR_CYCLE: begin
                rdata_o   = cycle_i;
                read_only = 1'b1;
            end
            CSR_INSTRET: begin
                rdata_o   = instret_i;
                read_only = 1'b1;
            end
            default:      known = 1'b0;
        endcase
    end

    //------------------------------------------------------------------
    // exception
    //------------------------------------------------------------------
    // address bits 9:8 hold the lowest level allowed to touch the CSR
    assign priv_fail = addr_i[9:8] > priv_lvl_i;

    // only an actual read or write can fault, mret and idle never do
    assign illegal = (read_i | write_i) & (~known | priv_fail | (write_i & read_only));

    assign exception_o.valid = illegal;
    assign exception_o.cause = illegal ? ILLEGAL_INSTR : '0;
    // tval is filled in by the commit stage
    assign exception_o.tval  = '0;

    // state update only for a write that passed every check
    assign write_en_o = write_i & ~illegal;

endmodule

// File: design/csr_machine_state.sv
//----------------------------------------------------------------------
// machine-mode registers and the current privilege level
// applies masked CSR writes, trap entry from the commit stage and mret
// trap updates win over a write in the same cycle
//----------------------------------------------------------------------
`timescale 1ns/1ps

module csr_machine_state (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    input  logic [riscv_csr_pkg::XLEN-1:0]       boot_addr_i,
    // legal write from the access check
    input  logic                                 write_en_i,
    input  logic [riscv_csr_pkg::CSR_ADDR_W-1:0] addr_i,
    input  logic [riscv_csr_pkg::XLEN-1:0]       wdata_i,
    input  csr_core_pkg::exception_t             ex_i,
    input  logic [riscv_csr_pkg::XLEN-1:0]       pc_i,
    input  logic                                 mret_i,
    // register views
    output riscv_csr_pkg::mstatus_t              mstatus_o,
    output logic [riscv_csr_pkg::XLEN-1:0]       mie_o,
    output logic [riscv_csr_pkg::XLEN-1:0]       mtvec_o,
    output logic [riscv_csr_pkg::XLEN-1:0]       mscratch_o,
    output logic [riscv_csr_pkg::XLEN-1:0]       mepc_o,
    output logic [riscv_csr_pkg::XLEN-1:0]       mcause_o,
    output logic [riscv_csr_pkg::XLEN-1:0]       mtval_o,
    output riscv_csr_pkg::priv_lvl_t             priv_lvl_o,
    output csr_core_pkg::trap_ctrl_t             trap_o,
    output logic                                 flush_o
);
    import riscv_csr_pkg::*;

    priv_lvl_t             priv_lvl_q, priv_lvl_n;
    mstatus_t              mstatus_q,  mstatus_n;
    logic [XLEN-1:0]       mie_q,      mie_n;
    logic [XLEN-1:0]       mtvec_q,    mtvec_n;
    logic [XLEN-1:0]       mscratch_q, mscratch_n;
    logic [XLEN-1:0]       mepc_q,     mepc_n;
    logic [XLEN-1:0]       mcause_q,   mcause_n;
    logic [XLEN-1:0]       mtval_q,    mtval_n;

    //------------------------------------------------------------------
    // next state
    //------------------------------------------------------------------
    always_comb begin
        priv_lvl_n = priv_lvl_q;
        mstatus_n  = mstatus_q;
        mie_n      = mie_q;
        mtvec_n    = mtvec_q;
        mscratch_n = mscratch_q;
        mepc_n     = mepc_q;
        mcause_n   = mcause_q;
        mtval_n    = mtval_q;

        if (write_en_i) begin
            case (csr_addr_e'(addr_i))
                CSR_MSTATUS: begin
                    mstatus_n = mstatus_t'(wdata_i & MSTATUS_MASK);
                    // mpp only holds M or U
                    if (mstatus_n.mpp != PRIV_LVL_M) begin
                        mstatus_n.mpp = PRIV_LVL_U;
                    end
                end
                CSR_MIE:      mie_n      = wdata_i & MIE_MASK;
                // bit 1 is reserved in the mode field
                CSR_MTVEC:    mtvec_n    = {wdata_i[XLEN-1:2], 1'b0, wdata_i[0]};
                CSR_MSCRATCH: mscratch_n = wdata_i;
                CSR_MEPC:     mepc_n     = {wdata_i[XLEN-1:1], 1'b0};
                CSR_MCAUSE:   mcause_n   = wdata_i;
                CSR_MTVAL:    mtval_n    = wdata_i;
                default:      mscratch_n = mscratch_q;
            endcase
        end

        // trap entry, always taken into M mode
        if (ex_i.valid) begin
            mcause_n       = ex_i.cause;
            mepc_n         = pc_i;
            mtval_n        = ex_i.tval;
            mstatus_n.mpie = mstatus_q.mie;
            mstatus_n.mie  = 1'b0;
            mstatus_n.mpp  = priv_lvl_q;
            priv_lvl_n     = PRIV_LVL_M;
        end

        // return from trap
        if (mret_i) begin
            mstatus_n.mie  = mstatus_q.mpie;
            priv_lvl_n     = mstatus_q.mpp;
            mstatus_n.mpp  = PRIV_LVL_U;
            mstatus_n.mpie = 1'b1;
        end
    end

    //------------------------------------------------------------------
    // registers
    //------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            priv_lvl_q <= PRIV_LVL_M;
            mstatus_q  <= '0;
            mie_q      <= '0;
            // direct mode at the boot address
            mtvec_q    <= {boot_addr_i[XLEN-1:2], 2'b00};
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtval_q    <= '0;
        end else begin
            priv_lvl_q <= priv_lvl_n;
            mstatus_q  <= mstatus_n;
            mie_q      <= mie_n;
            mtvec_q    <= mtvec_n;
            mscratch_q <= mscratch_n;
            mepc_q     <= mepc_n;
            mcause_q   <= mcause_n;
            mtval_q    <= mtval_n;
        end
    end

    // outputs
    assign mstatus_o  = mstatus_q;
    assign mie_o      = mie_q;
    assign mtvec_o    = mtvec_q;
    assign mscratch_o = mscratch_q;
    assign mepc_o     = mepc_q;
    assign mcause_o   = mcause_q;
    assign mtval_o    = mtval_q;
    assign priv_lvl_o = priv_lvl_q;

    assign trap_o.eret             = mret_i;
    assign trap_o.epc              = mepc_q;
    assign trap_o.trap_vector_base = mtvec_q;

    // a CSR write may change fetch context, unless a trap flushes anyway
    assign flush_o = write_en_i & ~ex_i.valid;

endmodule

// File: design/csr_counters.sv
//----------------------------------------------------------------------
// cycle and retired instruction counters, read only through the CSR file
//----------------------------------------------------------------------
`timescale 1ns/1ps

module csr_counters (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    // one pulse per retired instruction
    input  logic                           commit_ack_i,
    output logic [riscv_csr_pkg::XLEN-1:0] cycle_o,
    output logic [riscv_csr_pkg::XLEN-1:0] instret_o
);

    logic [riscv_csr_pkg::XLEN-1:0] cycle_q;
    logic [riscv_csr_pkg::XLEN-1:0] instret_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cycle_q   <= '0;
            instret_q <= '0;
        end else begin
            // free running
            cycle_q <= cycle_q + 1'b1;
            if (commit_ack_i) begin
                instret_q <= instret_q + 1'b1;
            end
        end
    end

    assign cycle_o   = cycle_q;
    assign instret_o = instret_q;

endmodule

// File: design/csr_regfile.sv
//----------------------------------------------------------------------
// top level of the machine-mode CSR file
// answers one request per cycle combinationally, updates state at the edge
//----------------------------------------------------------------------
`timescale 1ns/1ps

module csr_regfile (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic [riscv_csr_pkg::XLEN-1:0] boot_addr_i,
    input  csr_core_pkg::csr_req_t         req_i,
    // from the commit stage
    input  csr_core_pkg::exception_t       ex_i,
    input  logic [riscv_csr_pkg::XLEN-1:0] pc_i,
    input  logic                           commit_ack_i,
    output csr_core_pkg::csr_rsp_t         rsp_o,
    output csr_core_pkg::trap_ctrl_t       trap_o,
    output riscv_csr_pkg::priv_lvl_t       priv_lvl_o,
    output logic                           flush_o
);
    import riscv_csr_pkg::*;
    import csr_core_pkg::*;

    logic            read, write, mret, write_en;
    logic [XLEN-1:0] wdata, rdata;
    exception_t      csr_ex;
    mstatus_t        mstatus;
    logic [XLEN-1:0] mie, mtvec, mscratch, mepc, mcause, mtval;
    logic [XLEN-1:0] cycle, instret;

    csr_op_decode i_op_decode (
        .op_i    (req_i.op),
        .wdata_i (req_i.wdata),
        .rdata_i (rdata),
        .read_o  (read),
        .write_o (write),
        .mret_o  (mret),
        .wdata_o (wdata)
    );

    csr_access i_access (
        .addr_i      (req_i.addr),
        .read_i      (read),
        .write_i     (write),
        .priv_lvl_i  (priv_lvl_o),
        .mstatus_i   (mstatus),
        .mie_i       (mie),
        .mtvec_i     (mtvec),
        .mscratch_i  (mscratch),
        .mepc_i      (mepc),
        .mcause_i    (mcause),
        .mtval_i     (mtval),
        .cycle_i     (cycle),
        .instret_i   (instret),
        .rdata_o     (rdata),
        .exception_o (csr_ex),
        .write_en_o  (write_en)
    );

    csr_machine_state i_machine_state (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .boot_addr_i (boot_addr_i),
        .write_en_i  (write_en),
        .addr_i      (req_i.addr),
        .wdata_i     (wdata),
        .ex_i        (ex_i),
        .pc_i        (pc_i),
        .mret_i      (mret),
        .mstatus_o   (mstatus),
        .mie_o       (mie),
        .mtvec_o     (mtvec),
        .mscratch_o  (mscratch),
        .mepc_o      (mepc),
        .mcause_o    (mcause),
        .mtval_o     (mtval),
        .priv_lvl_o  (priv_lvl_o),
        .trap_o      (trap_o),
        .flush_o     (flush_o)
    );

    csr_counters i_counters (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .commit_ack_i (commit_ack_i),
        .cycle_o      (cycle),
        .instret_o    (instret)
    );

    // response to the core
    assign rsp_o.rdata     = rdata;
    assign rsp_o.exception = csr_ex;

endmodule

// File: verif/tb_csr_checks.svh
//----------------------------------------------------------------------
// compare tasks and result counters for the CSR file testbench
// included inside the testbench module after the package imports
//----------------------------------------------------------------------
`ifndef TB_CSR_CHECKS_SVH
`define TB_CSR_CHECKS_SVH

// mismatches seen so far and tests that finished clean
int err_cnt  = 0;
int pass_cnt = 0;

// one error line per wrong value
task automatic report_mismatch(input string what, input logic [63:0] act,
                               input logic [63:0] exp);
    err_cnt++;
    $display("** Error at time %0t: %s is %h, expected %h", $time, what, act, exp);
endtask

//----------------------------------------------------------------------
// response: read data and exception
//----------------------------------------------------------------------
task automatic check_rsp(input csr_rsp_t act, input csr_rsp_t exp, input logic chk_rdata,
                         input int idx);
    // rdata is don't care for idle, mret and faulting requests
    if (chk_rdata && act.rdata !== exp.rdata) begin
        report_mismatch($sformatf("test %0d rdata", idx), act.rdata, exp.rdata);
    end
    if (act.exception.valid !== exp.exception.valid) begin
        report_mismatch($sformatf("test %0d exception valid", idx),
                        act.exception.valid, exp.exception.valid);
    end
    if (exp.exception.valid && act.exception.cause !== exp.exception.cause) begin
        report_mismatch($sformatf("test %0d exception cause", idx),
                        act.exception.cause, exp.exception.cause);
    end
endtask

// trap control toward PC generation
task automatic check_trap(input trap_ctrl_t act, input trap_ctrl_t exp, input int idx);
    if (act.eret !== exp.eret) begin
        report_mismatch($sformatf("test %0d eret", idx), act.eret, exp.eret);
    end
    // epc only matters in the cycle of the return
    if (exp.eret && act.epc !== exp.epc) begin
        report_mismatch($sformatf("test %0d epc", idx), act.epc, exp.epc);
    end
    if (act.trap_vector_base !== exp.trap_vector_base) begin
        report_mismatch($sformatf("test %0d trap vector base", idx),
                        act.trap_vector_base, exp.trap_vector_base);
    end
endtask

task automatic check_priv(input priv_lvl_t act, input priv_lvl_t exp, input int idx);
    if (act !== exp) begin
        report_mismatch($sformatf("test %0d privilege level", idx), act, exp);
    end
endtask

task automatic check_flush(input logic act, input logic exp, input int idx);
    if (act !== exp) begin
        report_mismatch($sformatf("test %0d flush", idx), act, exp);
    end
endtask

`endif

// File: verif/tb_csr_regfile.sv
//----------------------------------------------------------------------
// testbench for the machine-mode CSR file
// builds a table of requests with expected answers and applies it,
// one entry per clock cycle, then prints a summary of the run
//----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_csr_regfile;
    import riscv_csr_pkg::*;
    import csr_core_pkg::*;

    // one table entry: stimulus for a cycle and what the DUT should answer
    typedef struct packed {
        csr_req_t        req;
        exception_t      ex;
        logic [XLEN-1:0] pc;
        logic            commit_ack;
        csr_rsp_t        exp_rsp;
        logic            chk_rdata;
        // >= 0 makes exp_rsp.rdata a delta to the rdata seen at that entry
        int              ref_idx;
        trap_ctrl_t      exp_trap;
        priv_lvl_t       exp_priv;
        logic            exp_flush;
    } vec_t;

    logic            clk;
    logic            rst_n;
    logic [XLEN-1:0] boot_addr;
    csr_req_t        req;
    exception_t      ex;
    logic [XLEN-1:0] pc;
    logic            commit_ack;
    csr_rsp_t        rsp;
    trap_ctrl_t      trap;
    priv_lvl_t       priv_lvl;
    logic            flush;

    vec_t            vectors[$];
    logic [XLEN-1:0] seen [0:127];
    logic [XLEN-1:0] exp_tvb;
    priv_lvl_t       exp_lvl;
    int              cyc_cnt   = 0;
    int              cyc_limit = 1000;

    `include "tb_csr_checks.svh"

    csr_regfile UUT (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .boot_addr_i  (boot_addr),
        .req_i        (req),
        .ex_i         (ex),
        .pc_i         (pc),
        .commit_ack_i (commit_ack),
        .rsp_o        (rsp),
        .trap_o       (trap),
        .priv_lvl_o   (priv_lvl),
        .flush_o      (flush)
    );

    // 40 ns clock
    initial clk = 1'b0;
    always #20 clk = ~clk;

    // run limit from the table length
    always @(posedge clk) begin
        cyc_cnt++;
        if (cyc_cnt > cyc_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cyc_limit);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic logic [XLEN-1:0] rnd64();
        return {$urandom, $urandom};
    endfunction

    // legal request, current privilege and trap vector filled in
    function automatic vec_t base_vec(input csr_op_e op, input logic [CSR_ADDR_W-1:0] addr,
            input logic [XLEN-1:0] wdata, input logic chk, input logic [XLEN-1:0] rdata,
            input logic flush_exp);
        vec_t v;
        v = '0;
        v.req.op = op;
        v.req.addr = addr;
        v.req.wdata = wdata;
        v.exp_rsp.rdata = rdata;
        v.chk_rdata = chk;
        v.ref_idx = -1;
        v.exp_trap.trap_vector_base = exp_tvb;
        v.exp_priv = exp_lvl;
        v.exp_flush = flush_exp;
        return v;
    endfunction

    // faulting request, no flush and rdata not checked
    function automatic vec_t ill_vec(input csr_op_e op, input logic [CSR_ADDR_W-1:0] addr,
            input logic [XLEN-1:0] wdata);
        vec_t v;
        v = base_vec(op, addr, wdata, 1'b0, '0, 1'b0);
        v.exp_rsp.exception.valid = 1'b1;
        v.exp_rsp.exception.cause = ILLEGAL_INSTR;
        return v;
    endfunction

    //------------------------------------------------------------------
    // stimulus and expected values
    //------------------------------------------------------------------
    task automatic build_vectors();
        logic [XLEN-1:0] r1, r2, r3, r4, r5, r6, r7, r8;
        logic [XLEN-1:0] p1, p2, p3, t1, t2, t3;
        vec_t e;
        r1 = rnd64();
        r2 = rnd64();
        r3 = rnd64();
        r4 = rnd64();
        r5 = rnd64();
        r6 = rnd64();
        r7 = rnd64();
        r8 = rnd64();
        p1 = rnd64();
        p2 = rnd64();
        p3 = rnd64();
        t1 = rnd64();
        t2 = rnd64();
        t3 = rnd64();
        exp_lvl = PRIV_LVL_M;
        exp_tvb = 64'h8000_0000;
        // reset state, entry 2 is the first cycle sample
        vectors.push_back(base_vec(CSR_READ, CSR_MSTATUS, '0, 1'b1, '0, 1'b0));
        vectors.push_back(base_vec(CSR_READ, CSR_MTVEC, '0, 1'b1, 64'h8000_0000, 1'b0));
        vectors.push_back(base_vec(CSR_READ, CSR_CYCLE, '0, 1'b0, '0, 1'b0));
        // write, set and clear on mscratch, rdata shows the old value
        vectors.push_back(base_vec(CSR_WRITE, CSR_MSCRATCH, r1, 1'b1, '0, 1'b1));
        vectors.push_back(base_vec(CSR_READ, CSR_MSCRATCH, '0, 1'b1, r1, 1'b0));
        vectors.push_back(base_vec(CSR_SET, CSR_MSCRATCH, r2, 1'b1, r1, 1'b1));
        vectors.push_back(base_vec(CSR_READ, CSR_MSCRATCH, '0, 1'b1, r1 | r2, 1'b0));
        vectors.push_back(base_vec(CSR_CLEAR, CSR_MSCRATCH, r3, 1'b1, r1 | r2, 1'b1));
        vectors.push_back(base_vec(CSR_READ, CSR_MSCRATCH, '0, 1'b1, (r1 | r2) & ~r3, 1'b0));
        // masked registers
        vectors.push_back(base_vec(CSR_WRITE, CSR_MTVEC, r4, 1'b1, 64'h8000_0000, 1'b1));
        exp_tvb = r4 & ~64'h2;
        vectors.push_back(base_vec(CSR_READ, CSR_MTVEC, '0, 1'b1, exp_tvb, 1'b0));
        vectors.push_back(base_vec(CSR_WRITE, CSR_MEPC, r5, 1'b1, '0, 1'b1));
        vectors.push_back(base_vec(CSR_READ, CSR_MEPC, '0, 1'b1, r5 & ~64'h1, 1'b0));
        vectors.push_back(base_vec(CSR_WRITE, CSR_MIE, '1, 1'b1, '0, 1'b1));
        vectors.push_back(base_vec(CSR_READ, CSR_MIE, '0, 1'b1, ~64'h111, 1'b0));
        vectors.push_back(base_vec(CSR_CLEAR, CSR_MIE, ~64'hFF, 1'b1, ~64'h111, 1'b1));
        vectors.push_back(base_vec(CSR_READ, CSR_MIE, '0, 1'b1, 64'hEE, 1'b0));
        vectors.push_back(base_vec(CSR_WRITE, CSR_MSTATUS, '1, 1'b1, '0, 1'b1));
        vectors.push_back(base_vec(CSR_READ, CSR_MSTATUS, '0, 1'b1, 64'h1888, 1'b0));
        // mpp of 2 is not a kept level and lands as U
        vectors.push_back(base_vec(CSR_WRITE, CSR_MSTATUS, 64'h1088, 1'b1, 64'h1888, 1'b1));
        vectors.push_back(base_vec(CSR_READ, CSR_MSTATUS, '0, 1'b1, 64'h88, 1'b0));
        // mret with mpp = U drops to user mode
        e = base_vec(MRET, '0, '0, 1'b0, '0, 1'b0);
        e.exp_trap.eret = 1'b1;
        e.exp_trap.epc = r5 & ~64'h1;
        vectors.push_back(e);
        exp_lvl = PRIV_LVL_U;
        vectors.push_back(ill_vec(CSR_READ, CSR_MSTATUS, '0));
        vectors.push_back(ill_vec(CSR_WRITE, CSR_MSCRATCH, r6));
        // cycle is readable from U, 22 entries after entry 2
        e = base_vec(CSR_READ, CSR_CYCLE, '0, 1'b1, 64'd22, 1'b0);
        e.ref_idx = 2;
        vectors.push_back(e);
        // trap entry from U with mie set back by the mret
        e = base_vec(CSR_NONE, '0, '0, 1'b0, '0, 1'b0);
        e.ex = '{valid: 1'b1, cause: 64'd7, tval: t1};
        e.pc = p1;
        vectors.push_back(e);
        exp_lvl = PRIV_LVL_M;
        vectors.push_back(base_vec(CSR_READ, CSR_MCAUSE, '0, 1'b1, 64'd7, 1'b0));
        vectors.push_back(base_vec(CSR_READ, CSR_MEPC, '0, 1'b1, p1, 1'b0));
        vectors.push_back(base_vec(CSR_READ, CSR_MTVAL, '0, 1'b1, t1, 1'b0));
        vectors.push_back(base_vec(CSR_READ, CSR_MSTATUS, '0, 1'b1, 64'h80, 1'b0));
        // trap entry from M with mie set
        vectors.push_back(base_vec(CSR_SET, CSR_MSTATUS, 64'h8, 1'b1, 64'h80, 1'b1));
        e = base_vec(CSR_NONE, '0, '0, 1'b0, '0, 1'b0);
        e.ex = '{valid: 1'b1, cause: 64'd11, tval: t2};
        e.pc = p2;
        vectors.push_back(e);
        vectors.push_back(base_vec(CSR_READ, CSR_MSTATUS, '0, 1'b1, 64'h1880, 1'b0));
        vectors.push_back(base_vec(CSR_READ, CSR_MCAUSE, '0, 1'b1, 64'd11, 1'b0));
        // trap beats a write to mepc in the same cycle, no flush
        e = base_vec(CSR_WRITE, CSR_MEPC, r7, 1'b1, p2, 1'b0);
        e.ex = '{valid: 1'b1, cause: 64'd3, tval: t3};
        e.pc = p3;
        vectors.push_back(e);
        vectors.push_back(base_vec(CSR_READ, CSR_MEPC, '0, 1'b1, p3, 1'b0));
        e = base_vec(MRET, '0, '0, 1'b0, '0, 1'b0);
        e.exp_trap.eret = 1'b1;
        e.exp_trap.epc = p3;
        vectors.push_back(e);
        vectors.push_back(base_vec(CSR_READ, CSR_MSTATUS, '0, 1'b1, 64'h80, 1'b0));
        // unknown address and read-only counters
        vectors.push_back(ill_vec(CSR_READ, 12'h3FF, '0));
        vectors.push_back(ill_vec(CSR_WRITE, CSR_CYCLE, r8));
        e = base_vec(CSR_READ, CSR_CYCLE, '0, 1'b1, 64'd16, 1'b0);
        e.ref_idx = 24;
        vectors.push_back(e);
        vectors.push_back(ill_vec(CSR_WRITE, CSR_MISA, r8));
        vectors.push_back(base_vec(CSR_READ, CSR_MISA, '0, 1'b1, ISA_CODE, 1'b0));
        vectors.push_back(base_vec(CSR_READ, CSR_MSCRATCH, '0, 1'b1, (r1 | r2) & ~r3, 1'b0));
        // instret counts two commit pulses
        vectors.push_back(base_vec(CSR_READ, CSR_INSTRET, '0, 1'b0, '0, 1'b0));
        e = base_vec(CSR_NONE, '0, '0, 1'b0, '0, 1'b0);
        e.commit_ack = 1'b1;
        vectors.push_back(e);
        vectors.push_back(base_vec(CSR_NONE, '0, '0, 1'b0, '0, 1'b0));
        vectors.push_back(e);
        e = base_vec(CSR_READ, CSR_INSTRET, '0, 1'b1, 64'd2, 1'b0);
        e.ref_idx = 44;
        vectors.push_back(e);
    endtask

    //------------------------------------------------------------------
    // main sequence
    //------------------------------------------------------------------
    initial begin
        vec_t     cur;
        csr_rsp_t exp_rsp;
        int       errs_before;
        rst_n      = 1'b0;
        boot_addr  = 64'h8000_0003;
        req        = '0;
        ex         = '0;
        pc         = '0;
        commit_ack = 1'b0;
        void'($urandom(32'h3a94));
        build_vectors();
        cyc_limit = 2 * vectors.size() + 20;
        repeat (2) @(posedge clk);
        #2 rst_n = 1'b1;
        for (int i = 0; i < vectors.size(); i++) begin
            @(posedge clk);
            #2;
            cur        = vectors[i];
            req        = cur.req;
            ex         = cur.ex;
            pc         = cur.pc;
            commit_ack = cur.commit_ack;
            // sample just before the next edge
            #35;
            exp_rsp = cur.exp_rsp;
            if (cur.ref_idx >= 0) begin
                exp_rsp.rdata = seen[cur.ref_idx] + cur.exp_rsp.rdata;
            end
            seen[i] = rsp.rdata;
            errs_before = err_cnt;
            check_rsp(rsp, exp_rsp, cur.chk_rdata, i);
            check_trap(trap, cur.exp_trap, i);
            check_priv(priv_lvl, cur.exp_priv, i);
            check_flush(flush, cur.exp_flush, i);
            if (err_cnt == errs_before) begin
                pass_cnt++;
                $display("test %0d ok", i);
            end else begin
                $display("test %0d FAIL", i);
            end
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors", vectors.size(), pass_cnt,
                 vectors.size() - pass_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+verif
design/riscv_csr_pkg.sv
design/csr_core_pkg.sv
design/csr_op_decode.sv
design/csr_access.sv
design/csr_machine_state.sv
design/csr_counters.sv
design/csr_regfile.sv
verif/tb_csr_regfile.sv
